/* Bender.yml */
package:
  name: symbol_decider

sources:
  - files:
      - source/nn_pkg.sv
      - source/neuron_mac.sv
      - source/dense_layer.sv
      - source/bias_add.sv
      - source/argmax_decider.sv
      - source/symbol_decider_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_symbol_decider.sv

/* files.f */
source/nn_pkg.sv
source/neuron_mac.sv
source/dense_layer.sv
source/bias_add.sv
source/argmax_decider.sv
source/symbol_decider_top.sv
+incdir+tb
tb/tb_symbol_decider.sv

/* source/argmax_decider.sv */
module argmax_decider
    import nn_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  data_t     score_1,
    input  data_t     score_2,
    input  data_t     score_3,
    input  data_t     score_4,
    output decision_t decision
);

    decision_t idx_lo;
    decision_t idx_hi;
    decision_t idx_max;
    data_t     max_lo;
    data_t     max_hi;

    // First round compares neighbours, the lower index keeps a tie
    always_comb begin
        if (score_1 >= score_2) begin
            idx_lo = 2'd0;
            max_lo = score_1;
        end else begin
            idx_lo = 2'd1;
            max_lo = score_2;
        end

        if (score_3 >= score_4) begin
            idx_hi = 2'd2;
            max_hi = score_3;
        end else begin
            idx_hi = 2'd3;
            max_hi = score_4;
        end
    end

    // Every index on the low side is below every index on the high side,
    // so favouring the low side on a tie keeps the lowest index overall
    always_comb begin
        if (max_lo >= max_hi) begin
            idx_max = idx_lo;
        end else begin
            idx_max = idx_hi;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            decision <= '0;
        end else begin
            decision <= idx_max;
        end
    end

    // The comparisons turn an unknown score into a known index without notice
    a_scores_known: assert property (
        @(posedge clk) disable iff (!rst) !$isunknown({score_1, score_2, score_3, score_4})
    ) else $error("score is unknown out of reset");

endmodule

/* source/bias_add.sv */
module bias_add
    import nn_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  data_t dot_1,
    input  data_t dot_2,
    input  data_t dot_3,
    input  data_t dot_4,
    output data_t score_1,
    output data_t score_2,
    output data_t score_3,
    output data_t score_4
);

    data_t sum_1;
    data_t sum_2;
    data_t sum_3;
    data_t sum_4;

    // Sums are DATA_W wide, so any carry out of the top bit is dropped
    always_comb begin
        sum_1 = dot_1 + BIASES[0];
        sum_2 = dot_2 + BIASES[1];
        sum_3 = dot_3 + BIASES[2];
        sum_4 = dot_4 + BIASES[3];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            score_1 <= '0;
            score_2 <= '0;
            score_3 <= '0;
            score_4 <= '0;
        end else begin
            score_1 <= sum_1;
            score_2 <= sum_2;
            score_3 <= sum_3;
            score_4 <= sum_4;
        end
    end

endmodule

/* source/dense_layer.sv */
module dense_layer
    import nn_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  valid,
    input  data_t h_1,
    input  data_t h_2,
    input  data_t h_3,
    input  data_t h_4,
    input  data_t h_5,
    output data_t dot_1,
    output data_t dot_2,
    output data_t dot_3,
    output data_t dot_4
);

    data_t h_1_q;
    data_t h_2_q;
    data_t h_3_q;
    data_t h_4_q;
    data_t h_5_q;

    // Hidden vector is captured only while valid is high and held otherwise
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            h_1_q <= '0;
            h_2_q <= '0;
            h_3_q <= '0;
            h_4_q <= '0;
            h_5_q <= '0;
        end else if (valid) begin
            h_1_q <= h_1;
            h_2_q <= h_2;
            h_3_q <= h_3;
            h_4_q <= h_4;
            h_5_q <= h_5;
        end
    end

    // An unknown valid would corrupt the held vector for every later cycle
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst) !$isunknown(valid)
    ) else $error("valid is unknown out of reset");

    // One neuron per output, each on its own row of the weight table
    neuron_mac #(.OUT_IDX(0)) u_neuron_1 (
        .clk (clk),   .rst (rst),
        .h_1 (h_1_q), .h_2 (h_2_q), .h_3 (h_3_q), .h_4 (h_4_q), .h_5 (h_5_q),
        .dot (dot_1)
    );

    neuron_mac #(.OUT_IDX(1)) u_neuron_2 (
        .clk (clk),   .rst (rst),
        .h_1 (h_1_q), .h_2 (h_2_q), .h_3 (h_3_q), .h_4 (h_4_q), .h_5 (h_5_q),
        .dot (dot_2)
    );

    neuron_mac #(.OUT_IDX(2)) u_neuron_3 (
        .clk (clk),   .rst (rst),
        .h_1 (h_1_q), .h_2 (h_2_q), .h_3 (h_3_q), .h_4 (h_4_q), .h_5 (h_5_q),
        .dot (dot_3)
    );

    neuron_mac #(.OUT_IDX(3)) u_neuron_4 (
        .clk (clk),   .rst (rst),
        .h_1 (h_1_q), .h_2 (h_2_q), .h_3 (h_3_q), .h_4 (h_4_q), .h_5 (h_5_q),
        .dot (dot_4)
    );

endmodule

/* source/neuron_mac.sv */
module neuron_mac
    import nn_pkg::*;
#(
    parameter int OUT_IDX = 0
) (
    input  logic  clk,
    input  logic  rst,
    input  data_t h_1,
    input  data_t h_2,
    input  data_t h_3,
    input  data_t h_4,
    input  data_t h_5,
    output data_t dot
);

    data_t h_vec [NUM_HIDDEN];
    prod_t prod  [NUM_HIDDEN];
    acc_t  sum;

    // The weight row must exist in the table
    if (OUT_IDX < 0 || OUT_IDX >= NUM_OUTPUTS) begin : g_bad_idx
        $error("neuron_mac OUT_IDX %0d out of range", OUT_IDX);
    end

    assign h_vec[0] = h_1;
    assign h_vec[1] = h_2;
    assign h_vec[2] = h_3;
    assign h_vec[3] = h_4;
    assign h_vec[4] = h_5;

    // Both operands are signed, so each product is exact at PROD_W bits
    always_comb begin
        for (int i = 0; i < NUM_HIDDEN; i++) begin
            prod[i] = h_vec[i] * WEIGHTS[OUT_IDX][i];
        end
    end

    // Full-width accumulation, no rounding until the final slice
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_HIDDEN; i++) begin
            sum = sum + acc_t'(prod[i]);
        end
    end

    // Drop the extra fractional bits and keep DATA_W bits above them
    // Upper bits are discarded, so large sums wrap around
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dot <= '0;
        end else begin
            dot <= sum[FRAC_BITS +: DATA_W];
        end
    end

endmodule

/* source/nn_pkg.sv */
package nn_pkg;

    // Fixed-point format shared by activations, weights, biases and scores
    localparam int DATA_W    = 14;
    localparam int FRAC_BITS = 10;

    // Layer dimensions
    localparam int NUM_HIDDEN  = 5;
    localparam int NUM_OUTPUTS = 4;

    // A product of two data values is exact at twice the data width
    localparam int PROD_W = 2 * DATA_W;

    // Three guard bits cover the growth of a five-term sum
    localparam int ACC_W = PROD_W + 3;

    // Symbol index width for four outputs
    localparam int DEC_W = 2;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic        [DEC_W-1:0]  decision_t;

    // Output weight matrix, row j holds the weights that feed output j
    // Column i is the weight applied to hidden activation i
    localparam data_t WEIGHTS [NUM_OUTPUTS][NUM_HIDDEN] = '{
        // Output 1
        '{
            14'b11110101101110,
            14'b00101100100110,
            14'b00000100101001,
            14'b11111100011001,
            14'b00001111010001
        },
        // Output 2
        '{
            14'b00010001111111,
            14'b11101111100011,
            14'b11011111110001,
            14'b11101111101100,
            14'b00000111110001
        },
        // Output 3
        '{
            14'b11011111000111,
            14'b11100001001110,
            14'b00001001011011,
            14'b00000001111111,
            14'b00000011000110
        },
        // Output 4
        '{
            14'b00001111101110,
            14'b11110101000101,
            14'b11110110101100,
            14'b00101111101001,
            14'b11011100110110
        }
    };

    // Per-output bias, added after the dot product
    localparam data_t BIASES [NUM_OUTPUTS] = '{
        14'b00000001010101,
        14'b11110101001001,
        14'b11111101011000,
        14'b00001011100100
    };

endpackage

/* source/symbol_decider_top.sv */
module symbol_decider_top
    import nn_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid,
    input  data_t     h_1,
    input  data_t     h_2,
    input  data_t     h_3,
    input  data_t     h_4,
    input  data_t     h_5,
    output data_t     score_1,
    output data_t     score_2,
    output data_t     score_3,
    output data_t     score_4,
    output decision_t decision
);

    // Dot products between the dense layer and the bias stage
    data_t dot_1;
    data_t dot_2;
    data_t dot_3;
    data_t dot_4;

    // Captures the vector at E and registers the dot products at E+1
    dense_layer u_dense_layer (
        .clk   (clk),
        .rst   (rst),
        .valid (valid),
        .h_1   (h_1),
        .h_2   (h_2),
        .h_3   (h_3),
        .h_4   (h_4),
        .h_5   (h_5),
        .dot_1 (dot_1),
        .dot_2 (dot_2),
        .dot_3 (dot_3),
        .dot_4 (dot_4)
    );

    // Scores registered at E+2
    bias_add u_bias_add (
        .clk     (clk),
        .rst     (rst),
        .dot_1   (dot_1),
        .dot_2   (dot_2),
        .dot_3   (dot_3),
        .dot_4   (dot_4),
        .score_1 (score_1),
        .score_2 (score_2),
        .score_3 (score_3),
        .score_4 (score_4)
    );

    // Decision registered at E+3
    argmax_decider u_argmax_decider (
        .clk      (clk),
        .rst      (rst),
        .score_1  (score_1),
        .score_2  (score_2),
        .score_3  (score_3),
        .score_4  (score_4),
        .decision (decision)
    );

endmodule

/* tb/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Score of output j for one hidden vector, worked out from the fixed-point rules.
// Products and the sum are formed at 64 bits, so nothing is lost before the slice.
function automatic data_t ref_score(
    input int    j,
    input data_t a,
    input data_t b,
    input data_t c,
    input data_t d,
    input data_t e
);
    data_t       h [NUM_HIDDEN];
    longint      acc;
    logic [63:0] acc_bits;
    data_t       dot;
    int          with_bias;
    logic [31:0] bias_bits;
    h[0] = a;
    h[1] = b;
    h[2] = c;
    h[3] = d;
    h[4] = e;
    acc = 0;
    for (int i = 0; i < NUM_HIDDEN; i++) begin
        acc = acc + longint'(h[i]) * longint'(WEIGHTS[j][i]);
    end
    // Bits 23 down to 10 of the sum, anything above is thrown away
    acc_bits = acc;
    dot = acc_bits[FRAC_BITS +: DATA_W];
    // The bias add keeps only the low 14 bits
    with_bias = int'(dot) + int'(BIASES[j]);
    bias_bits = with_bias;
    return bias_bits[DATA_W-1:0];
endfunction

// Index of the largest signed score, the first one found wins a tie
function automatic decision_t ref_decision(
    input data_t s_1,
    input data_t s_2,
    input data_t s_3,
    input data_t s_4
);
    data_t s [NUM_OUTPUTS];
    int    best;
    s[0] = s_1;
    s[1] = s_2;
    s[2] = s_3;
    s[3] = s_4;
    best = 0;
    for (int k = 1; k < NUM_OUTPUTS; k++) begin
        if (s[k] > s[best]) begin
            best = k;
        end
    end
    return best[DEC_W-1:0];
endfunction

task automatic check_score(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
        $display("MISMATCH at %0t ns: %s expected %0d, actual %0d",
                 $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "score check failed");
    end
endtask

task automatic check_decision(input string name, input decision_t expected,
                              input decision_t actual);
    if (actual !== expected) begin
        $display("MISMATCH at %0t ns: %s expected %0d, actual %0d",
                 $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "decision check failed");
    end
endtask

`endif

/* tb/tb_symbol_decider.sv */
module tb_symbol_decider
    import nn_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // About 240 cycles of stimulus, with margin
    localparam int    TIMEOUT_CYCLES = 300;
    localparam data_t MAX_VAL = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t MIN_VAL = {1'b1, {(DATA_W-1){1'b0}}};

    logic      clk;
    logic      rst;
    logic      valid;
    data_t     h_1, h_2, h_3, h_4, h_5;
    data_t     score_1, score_2, score_3, score_4;
    decision_t decision;

    integer    seed;
    int        cycle_count = 0;

    // Model of the hidden register and the expected-value delay lines
    data_t     hid_m [NUM_HIDDEN];
    data_t     score_line [2][NUM_OUTPUTS];
    decision_t dec_line [3];

    `include "tb_ref_model.svh"

    symbol_decider_top UUT (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .h_1      (h_1),
        .h_2      (h_2),
        .h_3      (h_3),
        .h_4      (h_4),
        .h_5      (h_5),
        .score_1  (score_1),
        .score_2  (score_2),
        .score_3  (score_3),
        .score_4  (score_4),
        .decision (decision)
    );

    always #50 clk = ~clk;

    function automatic data_t random_data();
        integer r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    task automatic apply_vector(input logic v, input data_t a, input data_t b,
                                input data_t c, input data_t d, input data_t e);
        @(negedge clk);
        valid = v;
        h_1 = a;
        h_2 = b;
        h_3 = c;
        h_4 = d;
        h_5 = e;
    endtask

    task automatic apply_random(input logic v);
        apply_vector(v, random_data(), random_data(), random_data(),
                     random_data(), random_data());
    endtask

    // Random data is offered with valid low, so it must be ignored
    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            apply_random(1'b0);
        end
    endtask

    // Entry 0 of each line is the value for the current hidden register,
    // deeper entries follow the register stages of the pipeline
    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_HIDDEN; i++) begin
                hid_m[i] = '0;
            end
            for (int j = 0; j < NUM_OUTPUTS; j++) begin
                score_line[0][j] = ref_score(j, hid_m[0], hid_m[1], hid_m[2], hid_m[3], hid_m[4]);
                score_line[1][j] = '0;
            end
            dec_line[0] = ref_decision(score_line[0][0], score_line[0][1],
                                       score_line[0][2], score_line[0][3]);
            dec_line[1] = '0;
            dec_line[2] = '0;
        end else begin
            dec_line[2] = dec_line[1];
            dec_line[1] = dec_line[0];
            for (int j = 0; j < NUM_OUTPUTS; j++) begin
                score_line[1][j] = score_line[0][j];
                score_line[0][j] = ref_score(j, hid_m[0], hid_m[1], hid_m[2], hid_m[3], hid_m[4]);
            end
            dec_line[0] = ref_decision(score_line[0][0], score_line[0][1],
                                       score_line[0][2], score_line[0][3]);
            if (valid) begin
                hid_m[0] = h_1;
                hid_m[1] = h_2;
                hid_m[2] = h_3;
                hid_m[3] = h_4;
                hid_m[4] = h_5;
            end
        end
    end

    // Outputs settle after the rising edge and are compared half a cycle later
    always @(negedge clk) begin
        check_score("score_1", score_line[1][0], score_1);
        check_score("score_2", score_line[1][1], score_2);
        check_score("score_3", score_line[1][2], score_3);
        check_score("score_4", score_line[1][3], score_4);
        check_decision("decision", dec_line[2], decision);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed = 32'hedacd3c8;
        clk = 1'b0;
        rst = 1'b0;
        valid = 1'b0;
        h_1 = '0;
        h_2 = '0;
        h_3 = '0;
        h_4 = '0;
        h_5 = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Idle after reset, the scores settle to the biases
        idle_cycles(6);

        // One vector, then the outputs must hold
        apply_random(1'b1);
        idle_cycles(6);

        // Back-to-back vectors keep three in flight
        for (int k = 0; k < 150; k++) begin
            apply_random(1'b1);
        end

        for (int k = 0; k < 40; k++) begin
            apply_random(random_data() % 2 != 0);
        end

        // Full-scale and mixed-sign vectors stress truncation and wraparound
        apply_vector(1'b1, MAX_VAL, MAX_VAL, MAX_VAL, MAX_VAL, MAX_VAL);
        idle_cycles(3);
        apply_vector(1'b1, MIN_VAL, MIN_VAL, MIN_VAL, MIN_VAL, MIN_VAL);
        idle_cycles(3);
        apply_vector(1'b1, MAX_VAL, MIN_VAL, MAX_VAL, MIN_VAL, MAX_VAL);
        idle_cycles(3);
        apply_vector(1'b1, MIN_VAL, MAX_VAL, MIN_VAL, MAX_VAL, MIN_VAL);
        idle_cycles(3);
        apply_vector(1'b1, MAX_VAL, MAX_VAL, MIN_VAL, MIN_VAL, data_t'(-1));
        idle_cycles(3);

        // With only h_3 at 847, scores 1 and 3 share the top value of 330
        apply_vector(1'b1, '0, '0, data_t'(847), '0, '0);
        idle_cycles(3);

        apply_vector(1'b1, '0, '0, '0, '0, '0);
        idle_cycles(5);

        @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule
